//--- rtl/apb_ram_macros.svh
//**************************************************
// APB RAM widths
// Word depth, data and lane widths, APB address width
//**************************************************
`ifndef APB_RAM_MACROS_SVH
`define APB_RAM_MACROS_SVH

// Word address width, 64 words
`define RAM_ADDR_W 6

`define RAM_DATA_W 32   // Data word width
`define RAM_COL_W  8    // One byte lane

// Byte address seen on the bus
`define APB_ADDR_W 12

`endif

//--- rtl/apb_ram_pkg.sv
//**************************************************
// APB RAM package
// Bus request, response and RAM port types
//**************************************************
`default_nettype none

`include "apb_ram_macros.svh"

package apb_ram_pkg;

   // APB4 request from the master
   typedef struct packed {
      logic                                psel;
      logic                                penable;
      logic                                pwrite;
      logic [`APB_ADDR_W-1:0]              paddr;
      logic [`RAM_DATA_W-1:0]              pwdata;
      logic [`RAM_DATA_W/`RAM_COL_W-1:0]   pstrb;
   } apb_req_t;

   typedef struct packed {
      logic [`RAM_DATA_W-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apb_rsp_t;

   // Single-port RAM access, one write enable per lane
   typedef struct packed {
      logic                                en;
      logic [`RAM_DATA_W/`RAM_COL_W-1:0]   we;
      logic [`RAM_ADDR_W-1:0]              addr;
      logic [`RAM_DATA_W-1:0]              din;
   } ram_req_t;

   typedef enum logic [1:0] {
      CLEARING  = 2'd0,  // Post-reset zero sweep
      IDLE      = 2'd1,
      READ_WAIT = 2'd2,  // RAM read issued
      RESPOND   = 2'd3   // pready high
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/ram_sp_be.sv
//**************************************************
// Single-port RAM, byte write enables
// Read-first, registered read data
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "apb_ram_macros.svh"

module ram_sp_be #(
   parameter int ADDR_W = `RAM_ADDR_W,
   parameter int DATA_W = `RAM_DATA_W
) (
   input  logic                  clk,
   input  apb_ram_pkg::ram_req_t ram_req,
   output logic [DATA_W-1:0]     dout
);

   localparam int COL_W   = `RAM_COL_W;
   localparam int NUM_COL = DATA_W / COL_W;
   localparam int DEPTH   = 2 ** ADDR_W;

   logic [DATA_W-1:0]  mem [DEPTH];
   logic [ADDR_W-1:0]  addr;
   logic [DATA_W-1:0]  din;
   logic [NUM_COL-1:0] we;

   // Port fields trimmed to this instance's widths
   assign addr = ram_req.addr[ADDR_W-1:0];
   assign din  = ram_req.din[DATA_W-1:0];
   assign we   = ram_req.we[NUM_COL-1:0];

   always_ff @(posedge clk) begin
      if (ram_req.en) begin
         for (int i = 0; i < NUM_COL; i++) begin
            if (we[i]) begin
               mem[addr][i*COL_W +: COL_W] <= din[i*COL_W +: COL_W];
            end
         end
         dout <= mem[addr];   // Old word, read-first
      end
   end

endmodule

`default_nettype wire

//--- rtl/ram_clear_counter.sv
//**************************************************
// RAM clear counter
// Sweeps every word once after reset
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "apb_ram_macros.svh"

module ram_clear_counter (
   input  logic                   clk,
   input  logic                   rst_n,
   output logic                   clear_busy,
   output logic [`RAM_ADDR_W-1:0] clear_addr
);

   localparam logic [`RAM_ADDR_W-1:0] LAST_ADDR = '1;

   logic [`RAM_ADDR_W-1:0] addr_q;
   logic                   busy_q;

   // One word per cycle, busy drops after the last one
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_q <= '0;
         busy_q <= 1'b1;
      end else if (busy_q) begin
         if (addr_q == LAST_ADDR) begin
            busy_q <= 1'b0;   // Sweep done, idle until reset
         end else begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   assign clear_busy = busy_q;
   assign clear_addr = addr_q;

endmodule

`default_nettype wire

//--- rtl/apb_ram_ctrl.sv
//**************************************************
// APB RAM controller
// APB4 slave FSM, range check and RAM port mux
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "apb_ram_macros.svh"

module apb_ram_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  apb_ram_pkg::apb_req_t  apb_req,
   output apb_ram_pkg::apb_rsp_t  apb_rsp,
   input  logic                   clear_busy,
   input  logic [`RAM_ADDR_W-1:0] clear_addr,
   output apb_ram_pkg::ram_req_t  ram_req,
   input  logic [`RAM_DATA_W-1:0] ram_dout
);

   import apb_ram_pkg::*;

   ctrl_state_e            state;
   logic                   pslverr_q;
   logic                   out_of_range;
   logic                   access;
   logic                   wr_commit;
   logic                   rd_issue;
   logic [`RAM_ADDR_W-1:0] word_addr;

   // Byte address to word address, anything above the word field is an error
   assign word_addr    = apb_req.paddr[`RAM_ADDR_W+1:2];
   assign out_of_range = |apb_req.paddr[`APB_ADDR_W-1:`RAM_ADDR_W+2];
   assign access       = apb_req.psel && apb_req.penable;

   // Write lands at the edge ending its access cycle
   assign wr_commit = (state == RESPOND) && access && apb_req.pwrite && !pslverr_q;
   assign rd_issue  = (state == READ_WAIT) && apb_req.psel;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= CLEARING;
         pslverr_q <= 1'b0;
      end else begin
         case (state)
            CLEARING: begin
               if (!clear_busy) begin
                  state <= IDLE;
               end
            end
            IDLE: begin
               // Setup phase, or an access held over from the clear
               if (apb_req.psel) begin
                  if (apb_req.pwrite || out_of_range) begin
                     state     <= RESPOND;
                     pslverr_q <= out_of_range;
                  end else begin
                     state <= READ_WAIT;
                  end
               end
            end
            READ_WAIT: begin
               state <= RESPOND;   // dout valid next cycle
            end
            RESPOND: begin
               state     <= IDLE;
               pslverr_q <= 1'b0;
            end
            default: begin
               state <= CLEARING;
            end
         endcase
      end
   end

   // Response, read data only for a good read
   always_comb begin
      apb_rsp.pready  = (state == RESPOND);
      apb_rsp.pslverr = pslverr_q;
      apb_rsp.prdata  = '0;
      if ((state == RESPOND) && !apb_req.pwrite && !pslverr_q) begin
         apb_rsp.prdata = ram_dout;
      end
   end

   // RAM port owner: clear sweep first, then APB
   always_comb begin
      if (clear_busy) begin
         ram_req.en   = 1'b1;
         ram_req.we   = '1;        // Whole word
         ram_req.addr = clear_addr;
         ram_req.din  = '0;
      end else begin
         ram_req.en   = wr_commit || rd_issue;
         ram_req.we   = wr_commit ? apb_req.pstrb : '0;
         ram_req.addr = word_addr;
         ram_req.din  = apb_req.pwdata;
      end
   end

endmodule

`default_nettype wire

//--- rtl/apb_ram_top.sv
//**************************************************
// APB RAM top
// Controller, clear counter and RAM
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "apb_ram_macros.svh"

module apb_ram_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  apb_ram_pkg::apb_req_t apb_req,
   output apb_ram_pkg::apb_rsp_t apb_rsp
);

   import apb_ram_pkg::*;

   logic                   clear_busy;
   logic [`RAM_ADDR_W-1:0] clear_addr;
   ram_req_t               ram_req;
   logic [`RAM_DATA_W-1:0] ram_dout;

   apb_ram_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .clear_busy (clear_busy),
      .clear_addr (clear_addr),
      .ram_req    (ram_req),
      .ram_dout   (ram_dout)
   );

   ram_clear_counter u_clear (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear_busy (clear_busy),
      .clear_addr (clear_addr)
   );

   // Widths follow the shared macros
   ram_sp_be #(
      .ADDR_W (`RAM_ADDR_W),
      .DATA_W (`RAM_DATA_W)
   ) u_ram (
      .clk     (clk),
      .ram_req (ram_req),
      .dout    (ram_dout)
   );

endmodule

`default_nettype wire

//--- dv/apb_ram_tb.sv
//**************************************************
// APB RAM testbench
// Random APB traffic checked against a word model
//**************************************************
`timescale 1ns/1ps
`default_nettype none

`include "apb_ram_macros.svh"

module apb_ram_tb;

   import apb_ram_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int DRIVE_DLY  = 1;   // Inputs change this long after the rising edge
   localparam int ADDR_W     = `RAM_ADDR_W;
   localparam int DATA_W     = `RAM_DATA_W;
   localparam int COL_W      = `RAM_COL_W;
   localparam int NUM_COL    = DATA_W / COL_W;
   localparam int DEPTH      = 2 ** ADDR_W;
   localparam int PADDR_W    = `APB_ADDR_W;
   localparam int HI_W       = PADDR_W - ADDR_W - 2;   // Bits above the word field
   localparam int NUM_RANDOM = 400;

   // First read, clear readback, write/read pairs, random loop with alias reads
   localparam int MAX_XFERS      = 1 + DEPTH + 2 * DEPTH + 2 * NUM_RANDOM;
   localparam int TIMEOUT_CYCLES = MAX_XFERS * 4 + DEPTH + 100;

   logic     clk;
   logic     rst_n;
   apb_req_t req;
   apb_rsp_t dut_rsp;

   integer seed = 32'h22da;
   int     error_cnt = 0;
   int     check_cnt = 0;
   int     cycle_cnt = 0;

   logic [DATA_W-1:0] model_mem [DEPTH];   // Expected RAM contents

   apb_ram_top u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .apb_req (req),
      .apb_rsp (dut_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [PADDR_W-1:0] good_paddr(input logic [ADDR_W-1:0] word);
      return {{HI_W{1'b0}}, word, 2'b00};
   endfunction

   function automatic logic [PADDR_W-1:0] bad_paddr(input logic [HI_W-1:0] hi,
                                                    input logic [ADDR_W-1:0] word);
      return {hi, word, 2'b00};
   endfunction

   // Only strobed lanes take the new bytes
   task automatic model_write(input logic [ADDR_W-1:0] word, input logic [DATA_W-1:0] data,
                              input logic [NUM_COL-1:0] strb);
      for (int i = 0; i < NUM_COL; i++) begin
         if (strb[i]) begin
            model_mem[word][i*COL_W +: COL_W] = data[i*COL_W +: COL_W];
         end
      end
   endtask

   // Setup, then access until pready, counting access cycles with pready low
   task automatic run_transfer(input logic write, input logic [PADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data,
                               input logic [NUM_COL-1:0] strb,
                               output apb_rsp_t rsp, output int waits);
      @(posedge clk);
      #DRIVE_DLY;
      req.psel    = 1'b1;
      req.penable = 1'b0;
      req.pwrite  = write;
      req.paddr   = addr;
      req.pwdata  = data;
      req.pstrb   = strb;
      @(posedge clk);
      #DRIVE_DLY;
      req.penable = 1'b1;
      waits = 0;
      @(negedge clk);   // Mid-cycle, outputs settled
      while (!dut_rsp.pready) begin
         waits++;
         @(negedge clk);
      end
      rsp = dut_rsp;
   endtask

   task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [NUM_COL-1:0] strb,
                            output apb_rsp_t rsp, output int waits);
      run_transfer(1'b1, addr, data, strb, rsp, waits);
   endtask

   task automatic apb_read(input logic [PADDR_W-1:0] addr,
                           output apb_rsp_t rsp, output int waits);
      run_transfer(1'b0, addr, '0, '0, rsp, waits);
   endtask

   task automatic bus_idle();
      @(posedge clk);
      #DRIVE_DLY;
      req = '0;
   endtask

   task automatic check_rsp(input string name, input apb_rsp_t exp_rsp, input apb_rsp_t act);
      check_cnt++;
      if (act.pslverr !== exp_rsp.pslverr) begin
         error_cnt++;
         $display("ERROR %s.pslverr expected %h actual %h", name, exp_rsp.pslverr,
                  act.pslverr);
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp_data,
                             input logic [DATA_W-1:0] act);
      check_cnt++;
      if (act !== exp_data) begin
         error_cnt++;
         $display("ERROR %s expected %h actual %h", name, exp_data, act);
      end
   endtask

   task automatic check_waits(input string name, input int exp_waits, input int act);
      check_cnt++;
      if (act != exp_waits) begin
         error_cnt++;
         $display("ERROR %s wait_cycles expected %h actual %h", name, exp_waits, act);
      end
   endtask

   task automatic write_and_check(input logic [ADDR_W-1:0] word, input logic [DATA_W-1:0] data,
                                  input logic [NUM_COL-1:0] strb);
      apb_rsp_t exp_rsp;
      apb_rsp_t rsp;
      int       waits;
      exp_rsp = '0;
      apb_write(good_paddr(word), data, strb, rsp, waits);
      check_rsp($sformatf("write word %0d", word), exp_rsp, rsp);
      check_waits($sformatf("write word %0d", word), 0, waits);   // Zero wait states
      model_write(word, data, strb);
   endtask

   task automatic read_and_check(input logic [ADDR_W-1:0] word);
      apb_rsp_t exp_rsp;
      apb_rsp_t rsp;
      int       waits;
      exp_rsp = '0;
      apb_read(good_paddr(word), rsp, waits);
      check_rsp($sformatf("read word %0d", word), exp_rsp, rsp);
      check_data($sformatf("prdata word %0d", word), model_mem[word], rsp.prdata);
      check_waits($sformatf("read word %0d", word), 1, waits);
   endtask

   // Out-of-range transfer, then the aliased in-range word must be untouched
   task automatic error_access(input logic write, input logic [ADDR_W-1:0] word,
                               input logic [DATA_W-1:0] data,
                               input logic [NUM_COL-1:0] strb);
      apb_rsp_t         exp_rsp;
      apb_rsp_t         rsp;
      int               waits;
      logic [31:0]      rnd;
      logic [HI_W-1:0]  hi;
      do begin
         rnd = $random(seed);
         hi  = rnd[HI_W-1:0];
      end while (hi == '0);
      exp_rsp         = '0;
      exp_rsp.pslverr = 1'b1;
      if (write) begin
         apb_write(bad_paddr(hi, word), data, strb, rsp, waits);
      end else begin
         apb_read(bad_paddr(hi, word), rsp, waits);
         check_data("prdata on error", '0, rsp.prdata);
      end
      check_rsp($sformatf("error access %h", bad_paddr(hi, word)), exp_rsp, rsp);
      check_waits("error access", 0, waits);
      read_and_check(word);
   endtask

   initial begin
      apb_rsp_t          exp_rsp;
      apb_rsp_t          rsp;
      int                waits;
      logic [31:0]       rnd;
      logic [ADDR_W-1:0] word;
      logic [DATA_W-1:0] data;
      logic [NUM_COL-1:0] strb;
      logic [2:0]        kind;

      rst_n = 1'b0;
      req   = '0;
      for (int i = 0; i < DEPTH; i++) begin
         model_mem[i] = '0;   // Clear walk leaves zeros
      end
      repeat (2) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      // A read right after reset has to sit out the clear
      exp_rsp = '0;
      apb_read(good_paddr('0), rsp, waits);
      check_cnt++;
      if (waits < DEPTH) begin
         error_cnt++;
         $display("First read after reset finished after only %0d wait cycles, %s %0d",
                  waits, "the clear needs at least", DEPTH);
      end
      check_rsp("first read", exp_rsp, rsp);
      check_data("prdata first read", '0, rsp.prdata);

      for (int w = 0; w < DEPTH; w++) begin
         word = w[ADDR_W-1:0];
         read_and_check(word);
      end

      // Byte lanes, each word written once and read back
      for (int w = 0; w < DEPTH; w++) begin
         word = w[ADDR_W-1:0];
         rnd  = $random(seed);
         data = rnd;
         rnd  = $random(seed);
         strb = rnd[NUM_COL-1:0];
         write_and_check(word, data, strb);
         read_and_check(word);
      end

      // Mixed traffic
      for (int n = 0; n < NUM_RANDOM; n++) begin
         rnd  = $random(seed);
         kind = rnd[2:0];
         word = rnd[ADDR_W+2:3];
         rnd  = $random(seed);
         data = rnd;
         rnd  = $random(seed);
         strb = rnd[NUM_COL-1:0];
         case (kind)
            3'd0:             write_and_check(word, data, '0);   // No lanes strobed
            3'd1, 3'd2:       write_and_check(word, data, strb);
            3'd3, 3'd4, 3'd5: read_and_check(word);
            3'd6:             error_access(1'b1, word, data, strb);
            default:          error_access(1'b0, word, data, strb);
         endcase
      end
      bus_idle();

      $display("Checks: %0d  Errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/apb_ram_pkg.sv
rtl/ram_sp_be.sv
rtl/ram_clear_counter.sv
rtl/apb_ram_ctrl.sv
rtl/apb_ram_top.sv
dv/apb_ram_tb.sv

//--- Makefile
# Verilator build and run of the APB RAM testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

obj_dir/Vapb_ram_tb: files.f rtl/*.sv rtl/*.svh dv/*.sv
	verilator --binary --timing --timescale 1ns/1ps --top-module apb_ram_tb \
		-f files.f -Mdir obj_dir

test: obj_dir/Vapb_ram_tb
	./obj_dir/Vapb_ram_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Everything OK$$" $(LOG) || (echo "Test run failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
